// File: hdl/atop_resolver_defines.svh
// --------------------
// Atomic resolver widths
// Bus widths and the response buffer depth
// --------------------

`ifndef ATOP_RESOLVER_DEFINES_SVH
`define ATOP_RESOLVER_DEFINES_SVH

// Address width of the subordinate and memory ports
`define ATOP_ADDR_W 32

// Data width equals the RISC-V word width
`define ATOP_DATA_W 32

`define ATOP_BE_W 4
`define ATOP_ID_W 4
`define ATOP_OP_W 6

// Number of entries in the response FIFO
`define ATOP_RSP_DEPTH 2

`endif

// File: hdl/atop_resolver_pkg.sv
// --------------------
// Atomic resolver types
// Opcodes, engine states and the response entry
// --------------------

`default_nettype none

`include "atop_resolver_defines.svh"

package atop_resolver_pkg;

  // Bit 5 of an OBI atomic opcode marks an atomic
  typedef enum logic [`ATOP_OP_W-1:0] {
    ATOP_NONE = 6'h00,
    AMO_ADD   = 6'h20,
    AMO_SWAP  = 6'h21,
    ATOP_LR   = 6'h22,
    ATOP_SC   = 6'h23,
    AMO_XOR   = 6'h24,
    AMO_OR    = 6'h28,
    AMO_AND   = 6'h2C,
    AMO_MIN   = 6'h30,
    AMO_MAX   = 6'h34,
    AMO_MINU  = 6'h38,
    AMO_MAXU  = 6'h3C
  } atop_e;

  typedef enum logic [1:0] {
    AMO_IDLE,
    AMO_WAIT_READ,
    AMO_WAIT_WRITE
  } amo_state_e;

  typedef struct packed {
    logic [`ATOP_DATA_W-1:0] rdata;
    logic                    err;
    logic                    exokay;
    logic [`ATOP_ID_W-1:0]   id;
  } rsp_entry_t;

endpackage

`default_nettype wire

// File: hdl/atop_resolver_if.sv
// --------------------
// Atomic resolver internal buses
// Reservation lookup and response push channels
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

// Request info seen by the reservation monitor and its decisions
interface atop_resv_if;
  logic                     fire;
  atop_resolver_pkg::atop_e op;
  logic [`ATOP_ADDR_W-1:0]  addr;
  logic [`ATOP_ID_W-1:0]    aid;
  logic                     we;
  // Store-conditional decision for the request on the bus right now
  logic                     sc_pass;
  // Registered LR or SC success of the last granted request
  logic                     lr_sc_ok;

  modport engine (output fire, op, addr, aid, we, input sc_pass, lr_sc_ok);
  modport monitor (input fire, op, addr, aid, we, output sc_pass, lr_sc_ok);
endinterface

// Response entries written into the response FIFO
interface atop_rsp_if;
  logic                    push;
  logic [`ATOP_DATA_W-1:0] rdata;
  logic                    err;
  logic                    exokay;
  logic [`ATOP_ID_W-1:0]   id;
  // Push may only rise while full is low
  logic                    full;

  modport engine (output push, rdata, err, exokay, id, input full);
  modport buffer (input push, rdata, err, exokay, id, output full);
endinterface

`default_nettype wire

// File: hdl/atop_lrsc_monitor.sv
// --------------------
// LR/SC reservation monitor
// Holds one reservation and decides store-conditional success
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_lrsc_monitor (
  input  logic         clk_i,
  input  logic         rst_ni,
  atop_resv_if.monitor resv_if
);

  logic                    resv_valid_q;
  logic                    resv_valid_d;
  logic [`ATOP_ADDR_W-1:0] resv_addr_q;
  logic [`ATOP_ID_W-1:0]   resv_id_q;
  logic                    lr_sc_ok_q;
  logic                    lr_sc_ok_d;
  logic                    is_lr;
  logic                    is_sc;
  logic                    is_amo;
  logic                    is_owner;
  logic                    addr_hit;
  logic                    take_resv;

  assign is_lr    = (resv_if.op == atop_resolver_pkg::ATOP_LR);
  assign is_sc    = (resv_if.op == atop_resolver_pkg::ATOP_SC);
  assign is_amo   = resv_if.op[`ATOP_OP_W-1] && !is_lr && !is_sc;
  assign is_owner = (resv_if.aid == resv_id_q);
  assign addr_hit = (resv_if.addr == resv_addr_q);

  // An LR never steals a reservation held by another requester
  assign take_resv = is_lr && (!resv_valid_q || is_owner);

  assign resv_if.sc_pass  = is_sc && resv_valid_q && is_owner && addr_hit;
  assign resv_if.lr_sc_ok = lr_sc_ok_q;

  always_comb begin
    resv_valid_d = resv_valid_q;
    lr_sc_ok_d   = 1'b0;
    if (take_resv) begin
      resv_valid_d = 1'b1;
      lr_sc_ok_d   = 1'b1;
    end
    // A store by someone else to the reserved word breaks the reservation
    if (!is_owner && addr_hit && (is_amo || (resv_if.we && !resv_if.op[`ATOP_OP_W-1]))) begin
      resv_valid_d = 1'b0;
    end
    // Any SC of the owner consumes the reservation
    if (is_sc && resv_valid_q && is_owner) begin
      resv_valid_d = 1'b0;
      lr_sc_ok_d   = resv_if.sc_pass;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_valid_q <= 1'b0;
      lr_sc_ok_q   <= 1'b0;
    end else if (resv_if.fire) begin
      resv_valid_q <= resv_valid_d;
      lr_sc_ok_q   <= lr_sc_ok_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resv_if.fire && take_resv) begin
      resv_addr_q <= resv_if.addr;
      resv_id_q   <= resv_if.aid;
    end
  end

endmodule

`default_nettype wire

// File: hdl/atop_amo_engine.sv
// --------------------
// AMO engine
// Grants requests, steers the memory port and runs each
// read-modify-write atomic as a read followed by a write
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_amo_engine (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic [`ATOP_ADDR_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_BE_W-1:0]   be_i,
  input  logic [`ATOP_DATA_W-1:0] wdata_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  logic [`ATOP_OP_W-1:0]   atop_i,
  output logic                    gnt_o,
  output logic                    mem_req_o,
  input  logic                    mem_gnt_i,
  output logic [`ATOP_ADDR_W-1:0] mem_addr_o,
  output logic                    mem_we_o,
  output logic [`ATOP_BE_W-1:0]   mem_be_o,
  output logic [`ATOP_DATA_W-1:0] mem_wdata_o,
  input  logic                    mem_rvalid_i,
  input  logic [`ATOP_DATA_W-1:0] mem_rdata_i,
  input  logic                    mem_err_i,
  atop_resv_if.engine             resv_if,
  atop_rsp_if.engine              rsp_if
);

  atop_resolver_pkg::atop_e      op_in;
  atop_resolver_pkg::atop_e      op_q;
  atop_resolver_pkg::amo_state_e state_q;
  atop_resolver_pkg::amo_state_e state_d;
  logic                          is_amo;
  logic                          outstanding_q;
  logic                          writeback;
  logic [`ATOP_ADDR_W-1:0]       addr_q;
  logic [`ATOP_ID_W-1:0]         aid_q;
  logic [`ATOP_DATA_W-1:0]       operand_b_q;
  logic [`ATOP_DATA_W-1:0]       old_q;
  logic [`ATOP_DATA_W-1:0]       operand_a;
  logic [`ATOP_DATA_W-1:0]       amo_result;
  logic [`ATOP_DATA_W:0]         diff;
  logic                          signed_cmp;
  logic                          a_less;

  assign op_in  = atop_resolver_pkg::atop_e'(atop_i);
  assign is_amo = atop_i[`ATOP_OP_W-1] && (op_in != atop_resolver_pkg::ATOP_LR) &&
                  (op_in != atop_resolver_pkg::ATOP_SC);

  // --------------------
  // Request mux
  // --------------------

  // Write-back is issued as soon as the read data arrives and repeated until granted
  assign writeback = ((state_q == atop_resolver_pkg::AMO_WAIT_READ) && mem_rvalid_i) ||
                     ((state_q == atop_resolver_pkg::AMO_WAIT_WRITE) && !outstanding_q);

  always_comb begin
    mem_req_o   = 1'b0;
    mem_addr_o  = addr_i;
    mem_we_o    = we_i;
    mem_be_o    = be_i;
    mem_wdata_o = wdata_i;
    gnt_o       = 1'b0;
    if (writeback) begin
      mem_req_o   = 1'b1;
      mem_addr_o  = addr_q;
      mem_we_o    = 1'b1;
      mem_be_o    = '1;
      mem_wdata_o = amo_result;
    end else if (state_q == atop_resolver_pkg::AMO_IDLE) begin
      mem_req_o = req_i && !outstanding_q && !rsp_if.full;
      gnt_o     = mem_req_o && mem_gnt_i;
      if (op_in == atop_resolver_pkg::ATOP_SC) begin
        // A failing SC turns into a read so that a response still comes back
        mem_we_o = resv_if.sc_pass;
      end else if (atop_i[`ATOP_OP_W-1]) begin
        mem_we_o = 1'b0;
      end
    end
  end

  assign resv_if.fire = gnt_o;
  assign resv_if.op   = op_in;
  assign resv_if.addr = addr_i;
  assign resv_if.aid  = aid_i;
  assign resv_if.we   = we_i;

  // --------------------
  // AMO state machine
  // --------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      atop_resolver_pkg::AMO_IDLE: begin
        if (gnt_o && is_amo) begin
          state_d = atop_resolver_pkg::AMO_WAIT_READ;
        end
      end
      atop_resolver_pkg::AMO_WAIT_READ: begin
        if (mem_rvalid_i) begin
          state_d = atop_resolver_pkg::AMO_WAIT_WRITE;
        end
      end
      atop_resolver_pkg::AMO_WAIT_WRITE: begin
        if (outstanding_q && mem_rvalid_i) begin
          state_d = atop_resolver_pkg::AMO_IDLE;
        end
      end
      default: state_d = atop_resolver_pkg::AMO_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= atop_resolver_pkg::AMO_IDLE;
      outstanding_q <= 1'b0;
      op_q          <= atop_resolver_pkg::ATOP_NONE;
    end else begin
      state_q       <= state_d;
      outstanding_q <= (outstanding_q && !mem_rvalid_i) || (mem_req_o && mem_gnt_i);
      if (gnt_o) begin
        op_q <= op_in;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      addr_q      <= addr_i;
      aid_q       <= aid_i;
      operand_b_q <= wdata_i;
    end
    if ((state_q == atop_resolver_pkg::AMO_WAIT_READ) && mem_rvalid_i) begin
      old_q <= mem_rdata_i;
    end
  end

  // --------------------
  // ALU
  // --------------------

  assign operand_a = (state_q == atop_resolver_pkg::AMO_WAIT_READ) ? mem_rdata_i : old_q;

  // Sign or zero extension to 33 bits makes one subtraction serve both compares
  assign signed_cmp = (op_q == atop_resolver_pkg::AMO_MIN) ||
                      (op_q == atop_resolver_pkg::AMO_MAX);
  assign diff = {signed_cmp & operand_a[`ATOP_DATA_W-1], operand_a} -
                {signed_cmp & operand_b_q[`ATOP_DATA_W-1], operand_b_q};
  assign a_less = diff[`ATOP_DATA_W];

  always_comb begin
    unique case (op_q)
      atop_resolver_pkg::AMO_ADD:  amo_result = operand_a + operand_b_q;
      atop_resolver_pkg::AMO_XOR:  amo_result = operand_a ^ operand_b_q;
      atop_resolver_pkg::AMO_OR:   amo_result = operand_a | operand_b_q;
      atop_resolver_pkg::AMO_AND:  amo_result = operand_a & operand_b_q;
      atop_resolver_pkg::AMO_MIN,
      atop_resolver_pkg::AMO_MINU: amo_result = a_less ? operand_a : operand_b_q;
      atop_resolver_pkg::AMO_MAX,
      atop_resolver_pkg::AMO_MAXU: amo_result = a_less ? operand_b_q : operand_a;
      default:                     amo_result = operand_b_q;
    endcase
  end

  // Only the response of the write-back is dropped
  assign rsp_if.push   = mem_rvalid_i && outstanding_q &&
                         (state_q != atop_resolver_pkg::AMO_WAIT_WRITE);
  assign rsp_if.rdata  = (op_q == atop_resolver_pkg::ATOP_SC) ?
                         {{(`ATOP_DATA_W-1){1'b0}}, !resv_if.lr_sc_ok} : mem_rdata_i;
  assign rsp_if.err    = mem_err_i;
  assign rsp_if.exokay = resv_if.lr_sc_ok;
  assign rsp_if.id     = aid_q;

endmodule

`default_nettype wire

// File: hdl/atop_rsp_buffer.sv
// --------------------
// Response buffer
// Fall-through FIFO in front of the subordinate response port
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_rsp_buffer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  atop_rsp_if.buffer              rsp_if,
  input  logic                    rready_i,
  output logic                    rvalid_o,
  output logic [`ATOP_DATA_W-1:0] rdata_o,
  output logic                    err_o,
  output logic                    exokay_o,
  output logic [`ATOP_ID_W-1:0]   rid_o
);

  localparam int unsigned PtrW = $clog2(`ATOP_RSP_DEPTH);
  localparam int unsigned CntW = $clog2(`ATOP_RSP_DEPTH + 1);

  atop_resolver_pkg::rsp_entry_t mem_q [`ATOP_RSP_DEPTH];
  atop_resolver_pkg::rsp_entry_t in_entry;
  atop_resolver_pkg::rsp_entry_t head;
  logic [PtrW-1:0]               wr_ptr_q;
  logic [PtrW-1:0]               rd_ptr_q;
  logic [CntW-1:0]               count_q;
  logic                          empty;
  logic                          pop;
  logic                          write;
  logic                          read;

  assign in_entry = '{rdata: rsp_if.rdata, err: rsp_if.err, exokay: rsp_if.exokay,
                      id: rsp_if.id};

  assign empty       = (count_q == '0);
  assign rsp_if.full = (count_q == CntW'(`ATOP_RSP_DEPTH));

  // When empty the incoming entry goes straight to the outputs
  assign head     = empty ? in_entry : mem_q[rd_ptr_q];
  assign rvalid_o = !empty || rsp_if.push;
  assign pop      = rvalid_o && rready_i;
  assign write    = rsp_if.push && !(empty && pop);
  assign read     = pop && !empty;

  assign rdata_o  = head.rdata;
  assign err_o    = head.err;
  assign exokay_o = head.exokay;
  assign rid_o    = head.id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (read) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + {{(CntW-1){1'b0}}, write} - {{(CntW-1){1'b0}}, read};
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) begin
      mem_q[wr_ptr_q] <= in_entry;
    end
  end

endmodule

`default_nettype wire

// File: hdl/atop_resolver_top.sv
// --------------------
// Atomic-operation resolver
// Turns RISC-V atomics into plain reads and writes
// toward a memory that this bus owns alone
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_resolver_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Subordinate side
  input  logic                    req_i,
  output logic                    gnt_o,
  input  logic [`ATOP_ADDR_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_BE_W-1:0]   be_i,
  input  logic [`ATOP_DATA_W-1:0] wdata_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  logic [`ATOP_OP_W-1:0]   atop_i,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output logic [`ATOP_DATA_W-1:0] rdata_o,
  output logic                    err_o,
  output logic                    exokay_o,
  output logic [`ATOP_ID_W-1:0]   rid_o,
  // Memory side
  output logic                    mem_req_o,
  input  logic                    mem_gnt_i,
  output logic [`ATOP_ADDR_W-1:0] mem_addr_o,
  output logic                    mem_we_o,
  output logic [`ATOP_BE_W-1:0]   mem_be_o,
  output logic [`ATOP_DATA_W-1:0] mem_wdata_o,
  input  logic                    mem_rvalid_i,
  input  logic [`ATOP_DATA_W-1:0] mem_rdata_i,
  input  logic                    mem_err_i
);

  atop_resv_if u_resv_if ();
  atop_rsp_if  u_rsp_if ();

  atop_lrsc_monitor u_lrsc_monitor (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .resv_if (u_resv_if)
  );

  atop_amo_engine u_amo_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .we_i         (we_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .aid_i        (aid_i),
    .atop_i       (atop_i),
    .gnt_o        (gnt_o),
    .mem_req_o    (mem_req_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_addr_o   (mem_addr_o),
    .mem_we_o     (mem_we_o),
    .mem_be_o     (mem_be_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_err_i    (mem_err_i),
    .resv_if      (u_resv_if),
    .rsp_if       (u_rsp_if)
  );

  atop_rsp_buffer u_rsp_buffer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rsp_if   (u_rsp_if),
    .rready_i (rready_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .err_o    (err_o),
    .exokay_o (exokay_o),
    .rid_o    (rid_o)
  );

endmodule

`default_nettype wire

// File: dv/atop_resolver_props.sv
// --------------------
// Resolver handshake assertions
// Bound into the top level of the resolver
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_resolver_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    req_i,
  input logic                    gnt_o,
  input logic                    rvalid_o,
  input logic                    rready_i,
  input logic [`ATOP_DATA_W-1:0] rdata_o,
  input logic [`ATOP_ID_W-1:0]   rid_o,
  input logic                    exokay_o,
  input logic                    mem_req_o
);

  logic seen_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_req_q <= 1'b0;
    end else if (req_i) begin
      seen_req_q <= 1'b1;
    end
  end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_o |-> req_i)
    else $error("gnt_o high without req_i");

  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rid_o) && $stable(exokay_o))
    else $error("response changed while rready_i was low");

  mem_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_req_q && !req_i |-> !mem_req_o)
    else $error("mem_req_o raised before any request");

endmodule

bind atop_resolver_top atop_resolver_props u_props (.*);

`default_nettype wire

// File: dv/atop_resolver_checker.sv
// --------------------
// Resolver checker
// Predicts every response from shadow state and compares in order
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_resolver_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    gnt_o,
  input  logic [`ATOP_ADDR_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_BE_W-1:0]   be_i,
  input  logic [`ATOP_DATA_W-1:0] wdata_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  logic [`ATOP_OP_W-1:0]   atop_i,
  input  logic                    rvalid_o,
  input  logic                    rready_i,
  input  logic [`ATOP_DATA_W-1:0] rdata_o,
  input  logic                    err_o,
  input  logic                    exokay_o,
  input  logic [`ATOP_ID_W-1:0]   rid_o,
  output int                      err_cnt_o,
  output int                      rsp_cnt_o
);

  logic [31:0] shadow_mem [16];
  logic        resv_valid;
  logic [31:0] resv_addr;
  logic [3:0]  resv_id;
  logic [31:0] exp_rdata_q [$];
  logic        exp_exokay_q [$];
  logic        exp_has_data_q [$];
  logic [3:0]  exp_id_q [$];

  // Must match the fill of the memory model in the testbench
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return 32'hC0DE0000 ^ (addr * 32'h9E3779B1);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Reference model of one granted request
  function automatic void predict(input logic [5:0] op, input logic we, input logic [3:0] be,
                                  input logic [31:0] wdata, input logic [3:0] aid,
                                  input logic [31:0] addr, output logic [31:0] exp_rdata,
                                  output logic exp_exokay, output logic exp_has_data,
                                  output logic [31:0] new_word);
    logic [31:0] old;
    logic        other_hit;
    old          = shadow_mem[addr[5:2]];
    new_word     = old;
    exp_rdata    = old;
    exp_exokay   = 1'b0;
    exp_has_data = 1'b1;
    other_hit    = resv_valid && (resv_id != aid) && (resv_addr == addr);
    case (atop_resolver_pkg::atop_e'(op))
      atop_resolver_pkg::ATOP_NONE: begin
        if (we) begin
          new_word     = merge_bytes(old, wdata, be);
          exp_has_data = 1'b0;
          if (other_hit) resv_valid = 1'b0;
        end
      end
      atop_resolver_pkg::ATOP_LR: begin
        if (!resv_valid || (resv_id == aid)) begin
          resv_valid = 1'b1;
          resv_addr  = addr;
          resv_id    = aid;
          exp_exokay = 1'b1;
        end
      end
      atop_resolver_pkg::ATOP_SC: begin
        exp_rdata = 32'd1;
        if (resv_valid && (resv_id == aid)) begin
          if (resv_addr == addr) begin
            new_word   = merge_bytes(old, wdata, be);
            exp_rdata  = 32'd0;
            exp_exokay = 1'b1;
          end
          resv_valid = 1'b0;
        end
      end
      default: begin
        case (atop_resolver_pkg::atop_e'(op))
          atop_resolver_pkg::AMO_SWAP: new_word = wdata;
          atop_resolver_pkg::AMO_ADD:  new_word = old + wdata;
          atop_resolver_pkg::AMO_XOR:  new_word = old ^ wdata;
          atop_resolver_pkg::AMO_OR:   new_word = old | wdata;
          atop_resolver_pkg::AMO_AND:  new_word = old & wdata;
          atop_resolver_pkg::AMO_MIN:  new_word = ($signed(old) < $signed(wdata)) ? old : wdata;
          atop_resolver_pkg::AMO_MAX:  new_word = ($signed(old) > $signed(wdata)) ? old : wdata;
          atop_resolver_pkg::AMO_MINU: new_word = (old < wdata) ? old : wdata;
          atop_resolver_pkg::AMO_MAXU: new_word = (old > wdata) ? old : wdata;
          default:                     new_word = old;
        endcase
        if (other_hit) resv_valid = 1'b0;
      end
    endcase
  endfunction

  initial begin
    err_cnt_o  = 0;
    rsp_cnt_o  = 0;
    resv_valid = 1'b0;
    resv_addr  = '0;
    resv_id    = '0;
    for (int i = 0; i < 16; i++) begin
      shadow_mem[i] = fill_word(32'(i * 4));
    end
  end

  // Requests are predicted in grant order, one outstanding at a time
  always @(posedge clk_i) begin
    logic [31:0] e_rdata;
    logic [31:0] e_word;
    logic        e_exokay;
    logic        e_has_data;
    if (rst_ni && req_i && gnt_o) begin
      predict(atop_i, we_i, be_i, wdata_i, aid_i, addr_i, e_rdata, e_exokay, e_has_data,
              e_word);
      shadow_mem[addr_i[5:2]] = e_word;
      exp_rdata_q.push_back(e_rdata);
      exp_exokay_q.push_back(e_exokay);
      exp_has_data_q.push_back(e_has_data);
      exp_id_q.push_back(aid_i);
    end
  end

  always @(posedge clk_i) begin
    logic [31:0] e_rdata;
    logic        e_exokay;
    logic        e_has_data;
    logic [3:0]  e_id;
    if (rst_ni && rvalid_o && rready_i) begin
      rsp_cnt_o++;
      if (exp_id_q.size() == 0) begin
        $display("Response arrived with no granted request waiting for it");
        err_cnt_o++;
      end else begin
        e_rdata    = exp_rdata_q.pop_front();
        e_exokay   = exp_exokay_q.pop_front();
        e_has_data = exp_has_data_q.pop_front();
        e_id       = exp_id_q.pop_front();
        if (rid_o !== e_id) begin
          $display("Error: rid_o expected %h got %h", e_id, rid_o);
          err_cnt_o++;
        end
        if (e_has_data && (rdata_o !== e_rdata)) begin
          $display("Error: rdata_o expected %h got %h", e_rdata, rdata_o);
          err_cnt_o++;
        end
        if (exokay_o !== e_exokay) begin
          $display("Error: exokay_o expected %h got %h", e_exokay, exokay_o);
          err_cnt_o++;
        end
        if (err_o !== 1'b0) begin
          $display("Error: err_o expected %h got %h", 1'b0, err_o);
          err_cnt_o++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/atop_resolver_tb.sv
// --------------------
// Resolver testbench
// Clock, reset, memory model, stimulus and watchdog
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "atop_resolver_defines.svh"

module atop_resolver_tb;

  // Requests over all tests: 16 + 54 + 3 + 11 + 40 + 300
  localparam int NumReq = 424;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        gnt_o;
  logic [31:0] addr_i;
  logic        we_i;
  logic [3:0]  be_i;
  logic [31:0] wdata_i;
  logic [3:0]  aid_i;
  logic [5:0]  atop_i;
  logic        rvalid_o;
  logic        rready_i;
  logic [31:0] rdata_o;
  logic        err_o;
  logic        exokay_o;
  logic [3:0]  rid_o;
  logic        mem_req_o;
  logic        mem_gnt_i;
  logic [31:0] mem_addr_o;
  logic        mem_we_o;
  logic [3:0]  mem_be_o;
  logic [31:0] mem_wdata_o;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        mem_err_i;
  int          err_cnt;
  int          rsp_cnt;
  int          issued_cnt;
  int          test_err_base;
  int          test_rsp_base;
  logic        backpressure;
  int          hold_cnt;
  logic [31:0] model_mem [16];
  logic        pend_q;
  int          pend_delay;
  logic [31:0] pend_data;

  atop_resolver_top u_dut (.*);

  atop_resolver_checker u_checker (
    .clk_i, .rst_ni, .req_i, .gnt_o, .addr_i, .we_i, .be_i, .wdata_i, .aid_i, .atop_i,
    .rvalid_o, .rready_i, .rdata_o, .err_o, .exokay_o, .rid_o,
    .err_cnt_o (err_cnt),
    .rsp_cnt_o (rsp_cnt)
  );

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return 32'hC0DE0000 ^ (addr * 32'h9E3779B1);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    #(NumReq * 20 * 100ns);
    $display("Watchdog expired before all responses arrived");
    $display("Test failed");
    $finish;
  end

  // --------------------
  // Memory model
  // --------------------

  always @(posedge clk_i) begin
    if (mem_rvalid_i) begin
      pend_q = 1'b0;
    end
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      pend_data = model_mem[mem_addr_o[5:2]];
      if (mem_we_o) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_be_o[b]) model_mem[mem_addr_o[5:2]][8*b +: 8] = mem_wdata_o[8*b +: 8];
        end
        pend_data = 32'h0;
      end
      pend_q     = 1'b1;
      pend_delay = $urandom_range(1, 3);
    end
  end

  always @(negedge clk_i) begin
    mem_gnt_i    <= ($urandom_range(0, 3) != 0);
    mem_rvalid_i <= 1'b0;
    if (pend_q) begin
      if (pend_delay == 1) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= pend_data;
      end
      pend_delay = pend_delay - 1;
    end
    // Back-pressure comes in random stretches
    if (hold_cnt > 0) begin
      hold_cnt = hold_cnt - 1;
    end else begin
      rready_i <= backpressure ? ($urandom_range(0, 1) == 1) : 1'b1;
      hold_cnt = backpressure ? $urandom_range(0, 4) : 0;
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  task automatic issue(input atop_resolver_pkg::atop_e op, input logic we, input logic [3:0] be,
                       input logic [3:0] word, input logic [31:0] wdata, input logic [3:0] aid);
    @(negedge clk_i);
    req_i   = 1'b1;
    atop_i  = op;
    we_i    = we;
    be_i    = be;
    addr_i  = {26'h0, word, 2'b00};
    wdata_i = wdata;
    aid_i   = aid;
    @(posedge clk_i);
    while (!gnt_o) @(posedge clk_i);
    issued_cnt++;
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic finish_test(input string name);
    while (rsp_cnt != issued_cnt) @(posedge clk_i);
    $display("%-12s responses %0d errors %0d", name, rsp_cnt - test_rsp_base,
             err_cnt - test_err_base);
    test_rsp_base = rsp_cnt;
    test_err_base = err_cnt;
  endtask

  function automatic atop_resolver_pkg::atop_e pick_op(input int sel);
    atop_resolver_pkg::atop_e ops [12];
    ops = '{atop_resolver_pkg::ATOP_NONE, atop_resolver_pkg::ATOP_NONE,
            atop_resolver_pkg::ATOP_LR, atop_resolver_pkg::ATOP_SC,
            atop_resolver_pkg::AMO_SWAP, atop_resolver_pkg::AMO_ADD,
            atop_resolver_pkg::AMO_XOR, atop_resolver_pkg::AMO_AND,
            atop_resolver_pkg::AMO_OR, atop_resolver_pkg::AMO_MIN,
            atop_resolver_pkg::AMO_MAX, atop_resolver_pkg::AMO_MINU};
    return (sel == 12) ? atop_resolver_pkg::AMO_MAXU : ops[sel];
  endfunction

  task automatic random_traffic(input int count);
    atop_resolver_pkg::atop_e op;
    logic                     we;
    for (int n = 0; n < count; n++) begin
      op = pick_op($urandom_range(0, 12));
      we = (op == atop_resolver_pkg::ATOP_NONE) ? 1'($urandom_range(0, 1)) :
           (op != atop_resolver_pkg::ATOP_LR);
      issue(op, we, (op == atop_resolver_pkg::ATOP_NONE) ? 4'($urandom_range(1, 15)) : 4'hF,
            4'($urandom_range(0, 3)), $urandom(), 4'($urandom_range(0, 3)));
    end
  endtask

  initial begin
    atop_resolver_pkg::atop_e amo_ops [9];
    logic [31:0]              pairs [2][2];
    void'($urandom(32'h421527c5));
    amo_ops = '{atop_resolver_pkg::AMO_SWAP, atop_resolver_pkg::AMO_ADD,
                atop_resolver_pkg::AMO_XOR, atop_resolver_pkg::AMO_AND,
                atop_resolver_pkg::AMO_OR, atop_resolver_pkg::AMO_MIN,
                atop_resolver_pkg::AMO_MAX, atop_resolver_pkg::AMO_MINU,
                atop_resolver_pkg::AMO_MAXU};
    pairs = '{'{32'h80000000, 32'h7FFFFFFF}, '{32'hFFFFFFFF, 32'h00000001}};
    rst_ni = 1'b0;
    req_i = 1'b0;
    addr_i = '0;
    we_i = 1'b0;
    be_i = '0;
    wdata_i = '0;
    aid_i = '0;
    atop_i = '0;
    rready_i = 1'b1;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    mem_err_i = 1'b0;
    backpressure = 1'b0;
    hold_cnt = 0;
    pend_q = 1'b0;
    pend_delay = 0;
    pend_data = '0;
    issued_cnt = 0;
    test_err_base = 0;
    test_rsp_base = 0;
    for (int i = 0; i < 16; i++) model_mem[i] = fill_word(32'(i * 4));
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int w = 0; w < 8; w++) begin
      issue(atop_resolver_pkg::ATOP_NONE, 1'b1, 4'(w + 3), 4'(w), 32'h11223344 * (w + 1), 4'(w));
    end
    for (int w = 0; w < 8; w++) begin
      issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'(w), '0, 4'(w + 8));
    end
    finish_test("plain_rw");

    foreach (amo_ops[k]) begin
      for (int p = 0; p < 2; p++) begin
        issue(atop_resolver_pkg::ATOP_NONE, 1'b1, 4'hF, 4'(k), pairs[p][0], 4'd1);
        issue(amo_ops[k], 1'b1, 4'hF, 4'(k), pairs[p][1], 4'd1);
        issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'(k), '0, 4'd1);
      end
    end
    finish_test("amo_ops");

    issue(atop_resolver_pkg::ATOP_LR, 1'b0, 4'hF, 4'd10, '0, 4'd2);
    issue(atop_resolver_pkg::ATOP_SC, 1'b1, 4'hF, 4'd10, 32'hCAFEF00D, 4'd2);
    issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'd10, '0, 4'd2);
    finish_test("lr_sc_pass");

    // Reservation broken by a write of another ID
    issue(atop_resolver_pkg::ATOP_LR, 1'b0, 4'hF, 4'd11, '0, 4'd2);
    issue(atop_resolver_pkg::ATOP_NONE, 1'b1, 4'hF, 4'd11, 32'h0BADBEEF, 4'd3);
    issue(atop_resolver_pkg::ATOP_SC, 1'b1, 4'hF, 4'd11, 32'h12345678, 4'd2);
    issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'd11, '0, 4'd2);
    // Reservation consumed by an SC to another word
    issue(atop_resolver_pkg::ATOP_LR, 1'b0, 4'hF, 4'd12, '0, 4'd2);
    issue(atop_resolver_pkg::ATOP_SC, 1'b1, 4'hF, 4'd13, 32'h55555555, 4'd2);
    issue(atop_resolver_pkg::ATOP_SC, 1'b1, 4'hF, 4'd12, 32'h66666666, 4'd2);
    issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'd12, '0, 4'd2);
    issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'd13, '0, 4'd2);
    issue(atop_resolver_pkg::ATOP_SC, 1'b1, 4'hF, 4'd14, 32'h77777777, 4'd1);
    issue(atop_resolver_pkg::ATOP_NONE, 1'b0, 4'hF, 4'd14, '0, 4'd1);
    finish_test("sc_fail");

    backpressure = 1'b1;
    random_traffic(40);
    finish_test("backpressure");
    backpressure = 1'b0;

    random_traffic(300);
    finish_test("random_mix");

    $display("Total responses %0d issued %0d errors %0d", rsp_cnt, issued_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: atop_resolver.f
+incdir+hdl
hdl/atop_resolver_pkg.sv
hdl/atop_resolver_if.sv
hdl/atop_lrsc_monitor.sv
hdl/atop_amo_engine.sv
hdl/atop_rsp_buffer.sv
hdl/atop_resolver_top.sv
dv/atop_resolver_props.sv
dv/atop_resolver_checker.sv
dv/atop_resolver_tb.sv

// File: Bender.yml
package:
  name: atop_resolver

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/atop_resolver_pkg.sv
      - hdl/atop_resolver_if.sv
      - hdl/atop_lrsc_monitor.sv
      - hdl/atop_amo_engine.sv
      - hdl/atop_rsp_buffer.sv
      - hdl/atop_resolver_top.sv
  - target: test
    files:
      - dv/atop_resolver_props.sv
      - dv/atop_resolver_checker.sv
      - dv/atop_resolver_tb.sv
